//--- design/ohci_defs.svh
// OHCI list walker defines for register offsets, reset values and the ED fetch size
`ifndef OHCI_DEFS_SVH
`define OHCI_DEFS_SVH

// APB byte offsets, decoded on paddr[7:0]
`define OHCI_REG_CONTROL         8'h04
`define OHCI_REG_PERIOD_HEAD_ED  8'h18
`define OHCI_REG_PERIOD_CUR_ED   8'h1C
`define OHCI_REG_CONTROL_HEAD_ED 8'h20
`define OHCI_REG_CONTROL_CUR_ED  8'h24
`define OHCI_REG_BULK_HEAD_ED    8'h28
`define OHCI_REG_BULK_CUR_ED     8'h2C
`define OHCI_REG_FM_INTERVAL     8'h34
`define OHCI_REG_FM_NUMBER       8'h3C
`define OHCI_REG_PERIODIC_START  8'h40

`define OHCI_HCFS_OPERATIONAL    2'b10     // HcControl.HCFS value for UsbOperational
`define OHCI_FM_INTERVAL_RST     14'd11999 // Full-speed frame in bit times
`define OHCI_PERIODIC_START_RST  14'd10799 // 90 % of the frame
`define OHCI_ED_WORDS            4         // DMA words per endpoint descriptor

`endif

//--- design/ohci_pkg.sv
// OHCI list walker package with shared widths, list and FSM enums and register bundles
package ohci_pkg;

  typedef logic [27:0] ed_addr_t;   // ED pointer, address bits [31:4]
  typedef logic [31:0] dma_word_t;
  typedef logic [31:0] dma_addr_t;  // Byte address on the DMA port
  typedef logic [1:0]  cbsr_t;      // Control EDs per bulk ED, minus one
  typedef logic [13:0] frame_cnt_t; // Bit-time count
  typedef logic [15:0] frame_num_t;

  typedef enum logic [1:0] {
    LIST_PERIODIC = 2'd0,
    LIST_CONTROL  = 2'd1,
    LIST_BULK     = 2'd2
  } list_e;

  typedef enum logic [1:0] {
    LS_IDLE   = 2'd0,
    LS_SELECT = 2'd1,
    LS_FETCH  = 2'd2,
    LS_WAIT   = 2'd3
  } ls_state_e;

  // Register fields seen by the hardware
  typedef struct packed {
    logic       operational;
    logic       ple;
    logic       cle;
    logic       ble;
    cbsr_t      cbsr;
    ed_addr_t   period_head;
    ed_addr_t   control_head;
    ed_addr_t   bulk_head;
    frame_cnt_t fm_interval;
    frame_cnt_t periodic_start;
  } reg2hw_t;

  // Current-ED updates from the list service, one strobe per pointer
  typedef struct packed {
    ed_addr_t period_cur;
    logic     period_cur_we;
    ed_addr_t control_cur;
    logic     control_cur_we;
    ed_addr_t bulk_cur;
    logic     bulk_cur_we;
  } ed_cur_t;

  typedef struct packed {
    ed_cur_t    cur;
    frame_num_t frame_num;
  } hw2reg_t;

endpackage

//--- design/ohci_ed_if.sv
// ED result bus from the descriptor unpacker to the list service
`timescale 1ns/1ns

interface ohci_ed_if;

  logic              valid;   // One-cycle pulse, no ready
  ohci_pkg::ed_addr_t next_ed; // NextED of the fetched descriptor
  logic              skip;    // sKip bit of word 0
  logic              empty;   // HeadP equals TailP
  ohci_pkg::list_e   list;    // List the fetch was issued for

  modport unpacker (
    output valid, next_ed, skip, empty, list
  );

  modport listservice (
    input valid, next_ed, skip, empty, list
  );

endinterface

//--- design/ohci_regs.sv
// APB register file with HcControl, ED pointer and frame registers of the host controller
`timescale 1ns/1ns
`include "ohci_defs.svh"

module ohci_regs (
  input  logic              soc_clk_i,
  input  logic              rst_n_i,
  input  logic [31:0]       paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  output ohci_pkg::reg2hw_t reg2hw_o,
  input  ohci_pkg::hw2reg_t hw2reg_i
);

  logic [7:0]           addr;
  logic                 wr_en;
  logic [1:0]           hcfs_q;       // Host controller functional state
  ohci_pkg::cbsr_t      cbsr_q;
  logic                 ple_q;
  logic                 cle_q;
  logic                 ble_q;
  ohci_pkg::ed_addr_t   per_head_q;
  ohci_pkg::ed_addr_t   ctl_head_q;
  ohci_pkg::ed_addr_t   blk_head_q;
  ohci_pkg::ed_addr_t   per_cur_q;
  ohci_pkg::ed_addr_t   ctl_cur_q;
  ohci_pkg::ed_addr_t   blk_cur_q;
  ohci_pkg::frame_cnt_t fm_interval_q;
  ohci_pkg::frame_cnt_t periodic_start_q;

  assign addr      = paddr_i[7:0];
  assign wr_en     = psel_i & penable_i & pwrite_i; // Access phase only
  assign pready_o  = psel_i & penable_i;            // Zero wait states
  assign pslverr_o = 1'b0;

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hcfs_q           <= 2'b00; // UsbReset
      cbsr_q           <= '0;
      ple_q            <= 1'b0;
      cle_q            <= 1'b0;
      ble_q            <= 1'b0;
      per_head_q       <= '0;
      ctl_head_q       <= '0;
      blk_head_q       <= '0;
      per_cur_q        <= '0;
      ctl_cur_q        <= '0;
      blk_cur_q        <= '0;
      fm_interval_q    <= `OHCI_FM_INTERVAL_RST;
      periodic_start_q <= `OHCI_PERIODIC_START_RST;
    end else begin
      if (wr_en) begin
        case (addr)
          `OHCI_REG_CONTROL: begin
            cbsr_q <= pwdata_i[1:0];
            ple_q  <= pwdata_i[2];
            cle_q  <= pwdata_i[4];  // Bit 3 (IE) not implemented
            ble_q  <= pwdata_i[5];
            hcfs_q <= pwdata_i[7:6];
          end
          `OHCI_REG_PERIOD_HEAD_ED:  per_head_q       <= pwdata_i[31:4];
          `OHCI_REG_CONTROL_HEAD_ED: ctl_head_q       <= pwdata_i[31:4];
          `OHCI_REG_BULK_HEAD_ED:    blk_head_q       <= pwdata_i[31:4];
          `OHCI_REG_PERIOD_CUR_ED:   per_cur_q        <= pwdata_i[31:4];
          `OHCI_REG_CONTROL_CUR_ED:  ctl_cur_q        <= pwdata_i[31:4];
          `OHCI_REG_BULK_CUR_ED:     blk_cur_q        <= pwdata_i[31:4];
          `OHCI_REG_FM_INTERVAL:     fm_interval_q    <= pwdata_i[13:0];
          `OHCI_REG_PERIODIC_START:  periodic_start_q <= pwdata_i[13:0];
          default: ;                                  // FmNumber is read-only
        endcase
      end
      // Hardware strobes come last and win over a same-cycle APB write
      if (hw2reg_i.cur.period_cur_we)  per_cur_q <= hw2reg_i.cur.period_cur;
      if (hw2reg_i.cur.control_cur_we) ctl_cur_q <= hw2reg_i.cur.control_cur;
      if (hw2reg_i.cur.bulk_cur_we)    blk_cur_q <= hw2reg_i.cur.bulk_cur;
    end
  end

  // Read mux, valid throughout the access phase
  always_comb begin
    prdata_o = '0;
    case (addr)
      `OHCI_REG_CONTROL:         prdata_o = {24'b0, hcfs_q, ble_q, cle_q, 1'b0, ple_q, cbsr_q};
      `OHCI_REG_PERIOD_HEAD_ED:  prdata_o = {per_head_q, 4'b0};
      `OHCI_REG_CONTROL_HEAD_ED: prdata_o = {ctl_head_q, 4'b0};
      `OHCI_REG_BULK_HEAD_ED:    prdata_o = {blk_head_q, 4'b0};
      `OHCI_REG_PERIOD_CUR_ED:   prdata_o = {per_cur_q, 4'b0};
      `OHCI_REG_CONTROL_CUR_ED:  prdata_o = {ctl_cur_q, 4'b0};
      `OHCI_REG_BULK_CUR_ED:     prdata_o = {blk_cur_q, 4'b0};
      `OHCI_REG_FM_INTERVAL:     prdata_o = {18'b0, fm_interval_q};
      `OHCI_REG_FM_NUMBER:       prdata_o = {16'b0, hw2reg_i.frame_num};
      `OHCI_REG_PERIODIC_START:  prdata_o = {18'b0, periodic_start_q};
      default: ;
    endcase
  end

  assign reg2hw_o.operational    = (hcfs_q == `OHCI_HCFS_OPERATIONAL);
  assign reg2hw_o.ple            = ple_q;
  assign reg2hw_o.cle            = cle_q;
  assign reg2hw_o.ble            = ble_q;
  assign reg2hw_o.cbsr           = cbsr_q;
  assign reg2hw_o.period_head    = per_head_q;
  assign reg2hw_o.control_head   = ctl_head_q;
  assign reg2hw_o.bulk_head      = blk_head_q;
  assign reg2hw_o.fm_interval    = fm_interval_q;
  assign reg2hw_o.periodic_start = periodic_start_q;

endmodule

//--- design/ohci_frame_timer.sv
// Frame timer, counts bit times down per frame and flags the periodic part
`timescale 1ns/1ns

module ohci_frame_timer (
  input  logic                 soc_clk_i,
  input  logic                 rst_n_i,
  input  logic                 run_i,            // Controller operational
  input  ohci_pkg::frame_cnt_t fm_interval_i,
  input  ohci_pkg::frame_cnt_t periodic_start_i,
  output ohci_pkg::frame_num_t frame_num_o,
  output logic                 frame_periodic_o, // 1 in the periodic part
  output logic                 frame_start_o     // Pulse at each frame boundary
);

  ohci_pkg::frame_cnt_t cnt_q;
  ohci_pkg::frame_num_t num_q;
  logic                 periodic_q;
  logic                 cnt_zero;

  assign cnt_zero = (cnt_q == '0);

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= '0; // First boundary right after start
      num_q      <= '0;
      periodic_q <= 1'b0;
    end else if (!run_i) begin
      periodic_q <= 1'b0;
    end else if (cnt_zero) begin
      cnt_q      <= fm_interval_i; // Reload for a new frame
      num_q      <= num_q + 16'd1;
      periodic_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q - 14'd1;
      if (cnt_q == periodic_start_i) periodic_q <= 1'b1;
    end
  end

  assign frame_num_o      = num_q;
  assign frame_periodic_o = periodic_q;
  assign frame_start_o    = run_i & cnt_zero;

endmodule

//--- design/ohci_listservice.sv
// List service FSM, picks the next ED list, fetches one ED and follows its NextED link
`timescale 1ns/1ns

module ohci_listservice (
  input  logic                soc_clk_i,
  input  logic                rst_n_i,
  input  ohci_pkg::reg2hw_t   reg2hw_i,
  output ohci_pkg::ed_cur_t   cur_o,
  input  logic                frame_periodic_i,
  input  logic                frame_start_i,
  output logic                dma_req_valid_o,
  output ohci_pkg::dma_addr_t dma_req_addr_o,
  input  logic                dma_req_ready_i,
  output ohci_pkg::list_e     req_list_o,
  ohci_ed_if.listservice      ed
);

  ohci_pkg::ls_state_e state_q, state_d;
  ohci_pkg::ed_addr_t  per_cur_q, ctl_cur_q, blk_cur_q;
  logic                per_we_q, ctl_we_q, blk_we_q;
  logic                per_done_q;   // Periodic list walked this frame
  logic [2:0]          cb_cnt_q;     // Control EDs served since last bulk ED
  ohci_pkg::ed_addr_t  req_ed_q;
  ohci_pkg::list_e     req_list_q;
  logic                per_avail, ctl_avail, blk_avail;
  logic                ctl_turn, sel_valid;
  ohci_pkg::list_e     sel_list;
  ohci_pkg::ed_addr_t  sel_ed, next_cur, res_head;
  logic                ctl_served;

  // An empty current pointer falls back to the list head
  function automatic ohci_pkg::ed_addr_t pick_ed(input ohci_pkg::ed_addr_t cur,
                                                 input ohci_pkg::ed_addr_t head);
    return (cur != '0) ? cur : head;
  endfunction

  assign per_avail = reg2hw_i.ple & frame_periodic_i & ~per_done_q
                   & ((per_cur_q != '0) | (reg2hw_i.period_head != '0));
  assign ctl_avail = reg2hw_i.cle & ((ctl_cur_q != '0) | (reg2hw_i.control_head != '0));
  assign blk_avail = reg2hw_i.ble & ((blk_cur_q != '0) | (reg2hw_i.bulk_head != '0));
  assign ctl_turn  = (cb_cnt_q <= {1'b0, reg2hw_i.cbsr});

  always_comb begin
    sel_valid = 1'b1;
    sel_list  = ohci_pkg::LIST_BULK;
    sel_ed    = pick_ed(blk_cur_q, reg2hw_i.bulk_head);
    if (per_avail) begin
      sel_list = ohci_pkg::LIST_PERIODIC;
      sel_ed   = pick_ed(per_cur_q, reg2hw_i.period_head);
    end else if (ctl_avail && (ctl_turn || !blk_avail)) begin // Bulk may hand its turn back
      sel_list = ohci_pkg::LIST_CONTROL;
      sel_ed   = pick_ed(ctl_cur_q, reg2hw_i.control_head);
    end else if (!blk_avail) begin
      sel_valid = 1'b0; // Nothing to serve
    end
  end

  // Result side, end of list wraps to the head
  always_comb begin
    case (ed.list)
      ohci_pkg::LIST_PERIODIC: res_head = reg2hw_i.period_head;
      ohci_pkg::LIST_CONTROL:  res_head = reg2hw_i.control_head;
      default:                 res_head = reg2hw_i.bulk_head;
    endcase
    next_cur = (ed.next_ed != '0) ? ed.next_ed : res_head;
  end

  // Skipped and empty control EDs count toward the ratio like any other
  assign ctl_served = ed.valid & (ed.list == ohci_pkg::LIST_CONTROL);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ohci_pkg::LS_IDLE:   if (reg2hw_i.operational) state_d = ohci_pkg::LS_SELECT;
      ohci_pkg::LS_SELECT: begin
        if (!reg2hw_i.operational) state_d = ohci_pkg::LS_IDLE;
        else if (sel_valid)        state_d = ohci_pkg::LS_FETCH;
      end
      ohci_pkg::LS_FETCH:  if (dma_req_ready_i) state_d = ohci_pkg::LS_WAIT;
      default:             if (ed.valid) state_d = ohci_pkg::LS_SELECT; // LS_WAIT
    endcase
  end

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ohci_pkg::LS_IDLE;
      per_cur_q  <= '0;
      ctl_cur_q  <= '0;
      blk_cur_q  <= '0;
      per_we_q   <= 1'b0;
      ctl_we_q   <= 1'b0;
      blk_we_q   <= 1'b0;
      per_done_q <= 1'b0;
      cb_cnt_q   <= '0;
      req_list_q <= ohci_pkg::LIST_PERIODIC;
    end else begin
      state_q  <= state_d;
      per_we_q <= 1'b0;
      ctl_we_q <= 1'b0;
      blk_we_q <= 1'b0;
      if (state_q == ohci_pkg::LS_SELECT && sel_valid) req_list_q <= sel_list;
      if (ed.valid) begin
        case (ed.list)
          ohci_pkg::LIST_PERIODIC: begin
            per_cur_q <= next_cur;
            per_we_q  <= 1'b1;
            if (ed.next_ed == '0) per_done_q <= 1'b1; // Once per frame
          end
          ohci_pkg::LIST_CONTROL: begin
            ctl_cur_q <= next_cur;
            ctl_we_q  <= 1'b1;
          end
          default: begin
            blk_cur_q <= next_cur;
            blk_we_q  <= 1'b1;
          end
        endcase
      end
      if (ctl_served && ctl_turn)                         cb_cnt_q <= cb_cnt_q + 3'd1;
      else if (ed.valid && ed.list == ohci_pkg::LIST_BULK) cb_cnt_q <= '0;
      // New frame restarts the periodic walk, overrides a same-cycle result
      if (frame_start_i) begin
        per_cur_q  <= reg2hw_i.period_head;
        per_we_q   <= 1'b1;
        per_done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (state_q == ohci_pkg::LS_SELECT && sel_valid) req_ed_q <= sel_ed;
  end

  assign dma_req_valid_o      = (state_q == ohci_pkg::LS_FETCH);
  assign dma_req_addr_o       = {req_ed_q, 4'b0};
  assign req_list_o           = req_list_q;
  assign cur_o.period_cur     = per_cur_q;
  assign cur_o.period_cur_we  = per_we_q;
  assign cur_o.control_cur    = ctl_cur_q;
  assign cur_o.control_cur_we = ctl_we_q;
  assign cur_o.bulk_cur       = blk_cur_q;
  assign cur_o.bulk_cur_we    = blk_we_q;

endmodule

//--- design/ohci_unpack_desc.sv
// Descriptor unpacker, gathers the four ED words and extracts NextED, skip and empty
`timescale 1ns/1ns
`include "ohci_defs.svh"

module ohci_unpack_desc (
  input  logic               soc_clk_i,
  input  logic               rst_n_i,
  input  logic               dma_rsp_valid_i,
  input  ohci_pkg::dma_word_t dma_rsp_data_i,
  input  ohci_pkg::list_e    req_list_i,
  ohci_ed_if.unpacker        ed
);

  localparam int unsigned WordCntW = $clog2(`OHCI_ED_WORDS);

  logic [WordCntW-1:0] cnt_q;    // Word index within the ED
  logic                valid_q;
  logic                last_word;
  logic                skip_q;
  ohci_pkg::ed_addr_t  tail_q;
  ohci_pkg::ed_addr_t  head_q;
  ohci_pkg::ed_addr_t  next_q;
  ohci_pkg::list_e     list_q;

  assign last_word = dma_rsp_valid_i && (cnt_q == WordCntW'(`OHCI_ED_WORDS - 1));

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= last_word; // Result one cycle after word 3
      if (dma_rsp_valid_i) cnt_q <= cnt_q + 1'b1;
    end
  end

  // Field capture, responses always arrive in word order
  always_ff @(posedge soc_clk_i) begin
    if (dma_rsp_valid_i) begin
      case (cnt_q)
        2'd0: begin
          skip_q <= dma_rsp_data_i[14];  // sKip in the endpoint control word
          list_q <= req_list_i;
        end
        2'd1:    tail_q <= dma_rsp_data_i[31:4]; // TailP
        2'd2:    head_q <= dma_rsp_data_i[31:4]; // HeadP, halt and carry bits dropped
        default: next_q <= dma_rsp_data_i[31:4]; // NextED
      endcase
    end
  end

  assign ed.valid   = valid_q;
  assign ed.next_ed = next_q;
  assign ed.skip    = skip_q;
  assign ed.empty   = (head_q == tail_q); // No TDs queued
  assign ed.list    = list_q;

endmodule

//--- design/ohci_top.sv
// OHCI ED list walker top, APB registers, frame timer, list service and ED unpacker
`timescale 1ns/1ns

module ohci_top (
  input  logic                soc_clk_i,
  input  logic                rst_n_i,
  // APB slave
  input  logic [31:0]         paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [31:0]         pwdata_i,
  output logic [31:0]         prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  // DMA read port
  output logic                dma_req_valid_o,
  output ohci_pkg::dma_addr_t dma_req_addr_o,
  input  logic                dma_req_ready_i,
  input  logic                dma_rsp_valid_i,
  input  ohci_pkg::dma_word_t dma_rsp_data_i
);

  ohci_pkg::reg2hw_t    reg2hw;
  ohci_pkg::hw2reg_t    hw2reg;
  ohci_pkg::ed_cur_t    ed_cur;         // Current-ED write-back
  ohci_pkg::frame_num_t frame_num;
  logic                 frame_periodic;
  logic                 frame_start;
  ohci_pkg::list_e      req_list;       // List of the outstanding fetch

  ohci_ed_if ed_res ();

  assign hw2reg = '{cur: ed_cur, frame_num: frame_num};

  ohci_regs i_regs (
    .soc_clk_i (soc_clk_i),
    .rst_n_i   (rst_n_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .reg2hw_o  (reg2hw),
    .hw2reg_i  (hw2reg)
  );

  ohci_frame_timer i_frame_timer (
    .soc_clk_i        (soc_clk_i),
    .rst_n_i          (rst_n_i),
    .run_i            (reg2hw.operational),
    .fm_interval_i    (reg2hw.fm_interval),
    .periodic_start_i (reg2hw.periodic_start),
    .frame_num_o      (frame_num),
    .frame_periodic_o (frame_periodic),
    .frame_start_o    (frame_start)
  );

  ohci_listservice i_listservice (
    .soc_clk_i        (soc_clk_i),
    .rst_n_i          (rst_n_i),
    .reg2hw_i         (reg2hw),
    .cur_o            (ed_cur),
    .frame_periodic_i (frame_periodic),
    .frame_start_i    (frame_start),
    .dma_req_valid_o  (dma_req_valid_o),
    .dma_req_addr_o   (dma_req_addr_o),
    .dma_req_ready_i  (dma_req_ready_i),
    .req_list_o       (req_list),
    .ed               (ed_res.listservice)
  );

  ohci_unpack_desc i_unpack_desc (
    .soc_clk_i       (soc_clk_i),
    .rst_n_i         (rst_n_i),
    .dma_rsp_valid_i (dma_rsp_valid_i),
    .dma_rsp_data_i  (dma_rsp_data_i),
    .req_list_i      (req_list),
    .ed              (ed_res.unpacker)
  );

endmodule

//--- tb/ohci_tb.sv
// Testbench for the OHCI ED list walker, vector driven APB and DMA memory model
`timescale 1ns/1ns

module ohci_tb;

  logic                soc_clk;
  logic                rst_n;
  logic [31:0]         paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic                dma_req_valid;
  ohci_pkg::dma_addr_t dma_req_addr;
  logic                dma_req_ready;
  logic                dma_rsp_valid;
  ohci_pkg::dma_word_t dma_rsp_data;

  logic [31:0]         vec [0:383];      // Three words per record
  ohci_pkg::dma_addr_t ed_addr_q [$];    // ED image
  ohci_pkg::dma_addr_t ed_next_q [$];
  int                  ed_kind_q [$];    // 1 control, 2 bulk, 3 periodic
  ohci_pkg::dma_addr_t fetch_q [$];      // Accepted request addresses
  int                  grant_cnt = 0;    // Requests the memory may accept
  int                  done_cnt  = 0;    // EDs fully returned
  int                  cycles    = 0;
  int                  limit     = 0;
  logic [31:0]         lfsr      = 32'hdb81532a;

  ohci_top ohci_top_i (
    .soc_clk_i       (soc_clk),
    .rst_n_i         (rst_n),
    .paddr_i         (paddr),
    .psel_i          (psel),
    .penable_i       (penable),
    .pwrite_i        (pwrite),
    .pwdata_i        (pwdata),
    .prdata_o        (prdata),
    .pready_o        (pready),
    .pslverr_o       (pslverr),
    .dma_req_valid_o (dma_req_valid),
    .dma_req_addr_o  (dma_req_addr),
    .dma_req_ready_i (dma_req_ready),
    .dma_rsp_valid_i (dma_rsp_valid),
    .dma_rsp_data_i  (dma_rsp_data)
  );

  initial begin
    soc_clk = 1'b0;
    forever #10 soc_clk = ~soc_clk; // 20 ns period
  end

  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input string what, input ohci_pkg::dma_addr_t got,
                            input ohci_pkg::dma_addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_word(input string what, input ohci_pkg::dma_word_t got,
                            input ohci_pkg::dma_word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // Frame numbers only move forward, so the check is against a lower bound
  task automatic check_frame(input string what, input ohci_pkg::frame_num_t got,
                             input ohci_pkg::frame_num_t least);
    if ($isunknown(got) || got < least) begin
      $display("CHECK FAILED at %0t ns: %s, got %0d, expected at least %0d",
               $time, what, got, least);
      stop_with_failure();
    end
  endtask

  // Galois LFSR, one step per bit
  function automatic int rand_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      val  = (val << 1) | lfsr[0];
    end
    return val;
  endfunction

  function automatic int find_ed(input ohci_pkg::dma_addr_t addr);
    for (int i = 0; i < ed_addr_q.size(); i++)
      if (ed_addr_q[i] == addr) return i;
    return -1;
  endfunction

  task automatic apb_access(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(posedge soc_clk);
    #2;
    paddr   = addr;  // Setup phase
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge soc_clk);
    #2;
    penable = 1'b1;
    @(negedge soc_clk);
    if (pready !== 1'b1 || pslverr !== 1'b0) begin
      $display("APB slave did not complete the access to %h cleanly", addr);
      stop_with_failure();
    end
    rdata = prdata; // Stable mid access phase
    @(posedge soc_clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Let one ED through the memory and wait until its result has settled
  task automatic fetch_one(output ohci_pkg::dma_addr_t addr);
    int target;
    target    = done_cnt + 1;
    grant_cnt = grant_cnt + 1;
    while (fetch_q.size() == 0) @(posedge soc_clk);
    addr = fetch_q.pop_front();
    while (done_cnt < target) @(posedge soc_clk);
    repeat (3) @(posedge soc_clk); // Result valid, then current-ED write-back
  endtask

  // DMA memory model, one outstanding request, 1 to 4 cycles of latency
  initial begin : dma_memory
    ohci_pkg::dma_addr_t addr;
    ohci_pkg::dma_word_t words [4];
    int                  idx;
    int                  delay;
    forever begin
      @(posedge soc_clk);
      #2;
      dma_req_ready = (grant_cnt > 0);
      @(negedge soc_clk);
      if (dma_req_ready && dma_req_valid) begin
        addr      = dma_req_addr;
        grant_cnt = grant_cnt - 1;
        fetch_q.push_back(addr);
        idx = find_ed(addr);
        if (idx < 0) begin
          $display("DMA read from address %h, which holds no ED", addr);
          stop_with_failure();
        end
        words[0] = (addr ^ 32'h0000a000) & ~32'h00004000;  // Control word, sKip clear
        words[1] = addr + 32'h00010000;                     // TailP
        words[2] = addr + 32'h00010000 + {27'b0, addr[4], 4'b0}; // Some EDs empty
        words[3] = ed_next_q[idx];
        @(posedge soc_clk);
        #2;
        dma_req_ready = 1'b0;
        delay = rand_bits(2);
        repeat (delay) @(posedge soc_clk);
        for (int i = 0; i < 4; i++) begin
          @(posedge soc_clk);
          #2;
          dma_rsp_valid = 1'b1;
          dma_rsp_data  = words[i];
        end
        @(posedge soc_clk);
        #2;
        dma_rsp_valid = 1'b0;
        done_cnt      = done_cnt + 1;
      end
    end
  end

  initial begin : watchdog
    forever begin
      @(posedge soc_clk);
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit) begin
        $display("Run stopped after %0d cycles without finishing the vectors", cycles);
        stop_with_failure();
      end
    end
  end

  initial begin : main
    int                   nrec;
    int                   kind;
    int                   per_frames;
    logic [3:0]           op;
    logic [31:0]          a;
    logic [31:0]          d;
    logic [31:0]          rd;
    ohci_pkg::dma_addr_t  got;
    ohci_pkg::frame_num_t fn;
    ohci_pkg::frame_num_t last_fn;
    ohci_pkg::frame_num_t first_fn;
    ohci_pkg::frame_num_t per_frame;
    rst_n         = 1'b0;
    paddr         = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    pwdata        = '0;
    dma_req_ready = 1'b0;
    dma_rsp_valid = 1'b0;
    dma_rsp_data  = '0;
    $readmemh("tb/ohci_vectors.txt", vec);
    nrec = 0;
    while (nrec < 128 && vec[nrec*3] !== 32'hf) nrec++;
    limit = nrec * 2000 + 20000;
    repeat (4) @(posedge soc_clk);
    #2;
    rst_n = 1'b1;
    for (int r = 0; r < nrec; r++) begin
      op = vec[r*3][3:0];
      a  = vec[r*3+1];
      d  = vec[r*3+2];
      case (op)
        4'h1, 4'h2, 4'h3: begin
          ed_addr_q.push_back(a);
          ed_next_q.push_back(d);
          ed_kind_q.push_back(int'(op));
        end
        4'h4: apb_access(a, 1'b1, d, rd);
        4'h5: begin
          apb_access(a, 1'b0, '0, rd);
          check_word($sformatf("register %h readback", a), rd, d);
        end
        4'h6: begin
          fetch_one(got);
          check_addr($sformatf("fetch of vector record %0d", r), got, a);
        end
        4'h7: fetch_one(got);
        4'h8: begin
          do begin
            repeat (50) @(posedge soc_clk);
            apb_access(32'h3c, 1'b0, '0, rd);
          end while (rd[15:0] < d[15:0]);
        end
        4'h9: begin
          apb_access(32'h3c, 1'b0, '0, rd);
          first_fn   = rd[15:0];
          last_fn    = first_fn;
          per_frame  = 16'hffff; // No periodic fetch seen yet
          per_frames = 0;
          for (int k = 0; k < int'(d); k++) begin
            fetch_one(got);
            kind = ed_kind_q[find_ed(got)];
            if (kind == 1) begin
              $display("Control ED %h fetched while the control list is disabled", got);
              stop_with_failure();
            end
            apb_access(32'h3c, 1'b0, '0, rd);
            fn = rd[15:0];
            check_frame("FmNumber monotonic", fn, last_fn);
            last_fn = fn;
            if (kind == 3) begin
              if (fn != per_frame) begin
                check_addr("first periodic ED of a frame", got, a);
                per_frames++;
              end
              per_frame = fn;
            end
          end
          if (per_frames < 2) begin
            $display("Periodic EDs were fetched in fewer than two frames");
            stop_with_failure();
          end
          check_frame("FmNumber advanced during observation", last_fn, first_fn + 16'd1);
        end
        default: begin
          $display("Vector record %0d has unknown op %h", r, op);
          stop_with_failure();
        end
      endcase
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- files.f
+incdir+design
design/ohci_pkg.sv
design/ohci_ed_if.sv
design/ohci_regs.sv
design/ohci_frame_timer.sv
design/ohci_listservice.sv
design/ohci_unpack_desc.sv
design/ohci_top.sv
tb/ohci_tb.sv

//--- Bender.yml
package:
  name: ohci_ed_walker

sources:
  - include_dirs:
      - design
    files:
      - design/ohci_pkg.sv
      - design/ohci_ed_if.sv
      - design/ohci_regs.sv
      - design/ohci_frame_timer.sv
      - design/ohci_listservice.sv
      - design/ohci_unpack_desc.sv
      - design/ohci_top.sv
  - target: test
    files:
      - tb/ohci_tb.sv

//--- tb/ohci_vectors.txt
// Columns: op addr data. Ops 1/2/3 control/bulk/periodic ED at addr with NextED data,
// 4 APB write, 5 APB read expect data, 6 expect fetch addr, 7 skip one fetch,
// 8 wait until FmNumber >= data, 9 observe data fetches with periodic head addr, f end
1 00001000 00001010
1 00001010 00001020
1 00001020 00001030
1 00001030 00000000
2 00002000 00002010
2 00002010 00000000
3 00003000 00003010
3 00003010 00000000
// Reset values and readback
5 00000034 00002edf
5 00000040 00002a2f
4 00000020 00001000
4 00000028 00002000
4 00000018 00003000
5 00000020 00001000
5 00000028 00002000
5 00000018 00003000
4 00000004 000000b2
5 00000004 000000b2
// Ratio 2, three control EDs per bulk ED, with wrap to the heads
6 00001000 00000000
6 00001010 00000000
6 00001020 00000000
6 00002000 00000000
6 00001030 00000000
5 00000024 00001000
6 00001000 00000000
6 00001010 00000000
6 00002010 00000000
5 0000002c 00002000
6 00001020 00000000
6 00001030 00000000
6 00001000 00000000
6 00002000 00000000
// Control list off, the pending control fetch drains first
4 00000004 000000a2
7 00000000 00000000
5 00000024 00001020
6 00002010 00000000
6 00002000 00000000
6 00002010 00000000
6 00002000 00000000
5 00000024 00001020
// Short frames with the periodic list on
4 00000034 0000012c
4 00000040 00000096
4 00000004 000000a6
8 00000000 00000003
9 00003000 00000028
f 00000000 00000000
